// File: tests/decode_patterns.txt
// test instr pc stall | wb_ex: we dst val ie src val | wb_mem: we dst val |
// expected: val_r1 val_r2 val_dst ctrl
// ctrl hex: dst src1 src2 (two digits each), incr, {ie rd wr wreg}, alu (3), jmp (2)
1 40000C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 0102030102000
1 42400C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 0102031904000
1 44800C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 0102032901000
1 46C00C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 0102034908000
1 49000C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 0102030110000
1 4B400C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 010203F900800
1 4D800C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 010203E900400
1 4FC00C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 010203C800200
2 04024684 0 0  0 0 0 0 0 0  0 0 0  0 0 12340000 0414110100000
2 08024684 0 0  1 4 AAAA5555 0 0 0  0 0 0  0 0 AAAA1234 0414110100000
2 00000085 0 0  0 0 0 0 0 0  0 0 0  AAAA5555 0 AAAA5555 0504000100000
2 00000084 0 0  0 0 0 0 0 0  0 0 0  AAAA5555 0 AAAA5555 0404000000000
2 70000C41 0 0  0 0 0 0 0 0  0 0 0  0 0 0 0000000000000
3 46001C66 0 0  0 0 0 1 3 3333  0 0 0  3333 0 0 0603070108000
3 46001C66 0 0  1 3 2222 1 3 4444  1 3 1111  1111 0 0 0603070108000
3 46001C66 0 0  1 3 2222 1 3 4444  0 0 0  2222 0 0 0603070108000
3 46001C66 0 0  0 0 0 0 0 0  0 0 0  4444 0 0 0603070108000
4 25FFC000 100 0  0 0 0 0 0 0  0 0 0  100 FFFFFFF0 0 000010C000010
4 28002001 200 0  0 0 0 0 0 0  0 0 0  200 8 200 0100080100010
4 34001000 300 0  0 0 0 0 0 0  0 0 0  300 4 0 0000040000004
4 12402440 400 0  1 9 ABCD 0 0 0  0 0 0  0 ABCD 0 0002091A00000
5 44000C41 0 0  0 0 0 0 0 0  0 0 0  0 4444 0 0102030101000
5 42000C41 0 1  0 0 0 0 0 0  0 0 0  0 4444 0 0102030101000
5 34001000 300 1  0 0 0 0 0 0  0 0 0  0 4444 0 0102030101000
5 00000000 0 1  0 0 0 0 0 0  0 0 0  0 4444 0 0102030101000
5 00000000 0 0  0 0 0 0 0 0  0 0 0  0 0 0 0000000000000

// File: build.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/register_file.sv
design/operand_forward.sv
design/instr_decoder.sv
design/instr_class_counters.sv
design/decode_stage.sv
tests/decode_stage_chk.sv
tests/decode_stage_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - design/isa_pkg.sv
  - design/pipe_pkg.sv
  - design/register_file.sv
  - design/operand_forward.sv
  - design/instr_decoder.sv
  - design/instr_class_counters.sv
  - design/decode_stage.sv
  - target: test
    files:
      - tests/decode_stage_chk.sv
      - tests/decode_stage_tb.sv

// File: tests/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    localparam int COLS      = 17;     // tokens per pattern line
    localparam int MAX_STEPS = 64;

    logic                clk;
    logic                reset;
    logic                stall;
    isa_pkg::instr_t     instruction;
    isa_pkg::word_t      pc;
    pipe_pkg::wb_rec_t   wb_ex;
    pipe_pkg::wb_rec_t   wb_mem;
    pipe_pkg::pipe_rec_t id_out;
    logic [31:0]         nop_count;
    logic [31:0]         jmp_count;
    logic [31:0]         alu_count;
    logic [31:0]         other_count;

    logic [63:0] pat [COLS*MAX_STEPS];
    int          num_steps;
    int          cycle_limit = 0;
    int          cycles = 0;
    int          passed = 0;
    int          failed = 0;
    int          test_failed = 0;

    decode_stage #(.STAT_WIDTH(32)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog limit is set once the patterns are loaded
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the pattern run never finished", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (act === exp) begin
            passed++;
        end else begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            failed++;
            test_failed++;
        end
    endtask

    // same layout as the ctrl column
    function automatic logic [51:0] control_word(input pipe_pkg::pipe_rec_t r);
        return {3'b0, r.dst_r, 3'b0, r.src_r1, 3'b0, r.src_r2, r.incr_r2,
                r.incr_r2_enable, r.read_mem, r.write_mem, r.write_reg,
                3'b0, r.mul_op, r.add_op, r.or_op, r.and_op, r.xor_op,
                r.shl_op, r.shr_op, r.cmp_op, r.ldrf_op,
                3'b0, r.jmpunc, r.jmpz, r.jmpnz, r.jmpc, r.jmpnc};
    endfunction

    // 0 nop, 1 jump, 2 alu, 3 anything else
    function automatic int class_index(input logic [31:0] instr);
        logic [3:0] op;
        op = instr[31:28];
        if (instr == 32'd0) begin
            return 0;
        end else if (op == isa_pkg::OP_JMPUNC || op == isa_pkg::OP_JMPF) begin
            return 1;
        end else if (op == isa_pkg::OP_ALU) begin
            return 2;
        end
        return 3;
    endfunction

    task automatic drive_step(input int k);
        int b;
        b = k * COLS;
        instruction = pat[b+1][31:0];
        pc          = pat[b+2][31:0];
        stall       = pat[b+3][0];
        wb_ex  = {pat[b+4][0], pat[b+5][4:0], pat[b+6][31:0],
                  pat[b+7][0], pat[b+8][4:0], pat[b+9][31:0]};
        wb_mem = {pat[b+10][0], pat[b+11][4:0], pat[b+12][31:0], 38'd0};
    endtask

    task automatic verify_step(input int k);
        int b;
        b = k * COLS;
        compare_value("id_out.val_r1", pat[b+13], {32'd0, id_out.val_r1});
        compare_value("id_out.val_r2", pat[b+14], {32'd0, id_out.val_r2});
        compare_value("id_out.val_dst", pat[b+15], {32'd0, id_out.val_dst});
        compare_value("id_out control fields", pat[b+16], {12'd0, control_word(id_out)});
        if (k == num_steps - 1 || pat[b+COLS] != pat[b]) begin   // last step of its test
            $display("test %0d finished with %0d errors", pat[b], test_failed);
            test_failed = 0;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int expect_cnt [4];
        expect_cnt  = '{default: 0};
        reset       = 1'b1;
        stall       = 1'b0;
        instruction = '0;
        pc          = '0;
        wb_ex       = '0;
        wb_mem      = '0;
        $readmemh("tests/decode_patterns.txt", pat);
        num_steps = 0;
        while (num_steps < MAX_STEPS && pat[num_steps*COLS] != 0) begin
            num_steps++;
        end
        cycle_limit = 2 * num_steps + 20;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        if (num_steps > 0) begin
            drive_step(0);
        end
        for (int k = 1; k <= num_steps; k++) begin
            @(posedge clk);
            #1;
            verify_step(k - 1);
            if (k < num_steps) begin
                drive_step(k);
            end
        end

        // one class per step including stalled steps
        for (int k = 0; k < num_steps; k++) begin
            expect_cnt[class_index(pat[k*COLS+1][31:0])]++;
        end
        compare_value("nop_count", expect_cnt[0], nop_count);
        compare_value("jmp_count", expect_cnt[1], jmp_count);
        compare_value("alu_count", expect_cnt[2], alu_count);
        compare_value("other_count", expect_cnt[3], other_count);
        $display("test 6 finished with %0d errors", test_failed);
        if (num_steps == 0) begin
            $display("no steps could be read from the pattern file");
            failed++;
        end

        // the bound checker resolves the last step one edge later
        @(posedge clk);
        #1;
        if (dut0.chk0.error_count != 0) begin
            $display("%0d bound assertions on the DUT failed", dut0.chk0.error_count);
            failed += dut0.chk0.error_count;
        end

        $display("%0d checks passed, %0d checks failed", passed, failed);
        if (failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/decode_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_chk #(
    parameter int STAT_WIDTH = 32
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  stall,
    input pipe_pkg::pipe_rec_t   id_out,
    input logic [STAT_WIDTH-1:0] nop_count,
    input logic [STAT_WIDTH-1:0] jmp_count,
    input logic [STAT_WIDTH-1:0] alu_count,
    input logic [STAT_WIDTH-1:0] other_count
);

    int error_count = 0;    // failed assertions so far

    // record cleared by reset
    assert property (@(posedge clk) reset |=> (id_out == '0))
        else begin
            $error("id_out not zero after a reset edge");
            error_count++;
        end

    assert property (@(posedge clk) (!reset && stall) |=> $stable(id_out))
        else begin
            $error("id_out changed across a stalled edge");
            error_count++;
        end

    // one class counter steps per running cycle
    assert property (@(posedge clk) !reset |=> $onehot({
            nop_count != $past(nop_count), jmp_count != $past(jmp_count),
            alu_count != $past(alu_count), other_count != $past(other_count)}))
        else begin
            $error("not exactly one statistics counter stepped");
            error_count++;
        end

endmodule

bind decode_stage decode_stage_chk #(.STAT_WIDTH(STAT_WIDTH)) chk0 (
    .clk(clk), .reset(reset), .stall(stall), .id_out(id_out),
    .nop_count(nop_count), .jmp_count(jmp_count),
    .alu_count(alu_count), .other_count(other_count)
);

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int STAT_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  isa_pkg::instr_t       instruction,
    input  isa_pkg::word_t        pc,
    input  pipe_pkg::wb_rec_t     wb_ex,
    input  pipe_pkg::wb_rec_t     wb_mem,
    output pipe_pkg::pipe_rec_t   id_out,
    output logic [STAT_WIDTH-1:0] nop_count,
    output logic [STAT_WIDTH-1:0] jmp_count,
    output logic [STAT_WIDTH-1:0] alu_count,
    output logic [STAT_WIDTH-1:0] other_count
);

    isa_pkg::reg_idx_t idx_dst;
    isa_pkg::reg_idx_t idx_r1;
    isa_pkg::reg_idx_t idx_r2;
    isa_pkg::word_t    rf_dst;
    isa_pkg::word_t    rf_r1;
    isa_pkg::word_t    rf_r2;
    isa_pkg::word_t    fwd_dst;
    isa_pkg::word_t    fwd_r1;
    isa_pkg::word_t    fwd_r2;

    assign idx_dst = instruction[isa_pkg::DST_HI:isa_pkg::DST_LO];
    assign idx_r1  = instruction[isa_pkg::SRC1_HI:isa_pkg::SRC1_LO];
    assign idx_r2  = instruction[isa_pkg::SRC2_HI:isa_pkg::SRC2_LO];

    //////////////////////////////////////////////////
    // operand fetch

    register_file #(.NUM_REGS(isa_pkg::NUM_REGS)) u_rf (
        .clk(clk), .reset(reset),
        .rd_idx0(idx_dst), .rd_idx1(idx_r1), .rd_idx2(idx_r2),
        .wb_ex(wb_ex), .wb_mem(wb_mem),
        .rd_val0(rf_dst), .rd_val1(rf_r1), .rd_val2(rf_r2)
    );

    operand_forward u_fwd_r1 (
        .idx(idx_r1), .rf_val(rf_r1), .wb_ex(wb_ex), .wb_mem(wb_mem), .val(fwd_r1)
    );

    operand_forward u_fwd_r2 (
        .idx(idx_r2), .rf_val(rf_r2), .wb_ex(wb_ex), .wb_mem(wb_mem), .val(fwd_r2)
    );

    operand_forward u_fwd_dst (
        .idx(idx_dst), .rf_val(rf_dst), .wb_ex(wb_ex), .wb_mem(wb_mem), .val(fwd_dst)
    );

    //////////////////////////////////////////////////
    // decode and statistics

    instr_decoder u_dec (
        .clk(clk), .reset(reset), .stall(stall),
        .instruction(instruction), .pc(pc),
        .fwd_r1(fwd_r1), .fwd_r2(fwd_r2), .fwd_dst(fwd_dst),
        .id_out(id_out)
    );

    instr_class_counters #(.STAT_WIDTH(STAT_WIDTH)) u_stats (
        .clk(clk), .reset(reset), .instruction(instruction),
        .nop_count(nop_count), .jmp_count(jmp_count),
        .alu_count(alu_count), .other_count(other_count)
    );

endmodule

`default_nettype wire

// File: design/instr_class_counters.sv
`timescale 1ns/1ps
`default_nettype none

module instr_class_counters #(
    parameter int STAT_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  isa_pkg::instr_t       instruction,
    output logic [STAT_WIDTH-1:0] nop_count,
    output logic [STAT_WIDTH-1:0] jmp_count,
    output logic [STAT_WIDTH-1:0] alu_count,
    output logic [STAT_WIDTH-1:0] other_count
);

    isa_pkg::opcode_t opcode;
    logic             is_jmp;

    assign opcode = instruction[isa_pkg::OPC_HI:isa_pkg::OPC_LO];
    assign is_jmp = (opcode == isa_pkg::OP_JMPUNC) || (opcode == isa_pkg::OP_JMPF);

    // one class per cycle, stalled cycles count too
    always_ff @(posedge clk) begin
        if (reset) begin
            nop_count   <= '0;
            jmp_count   <= '0;
            alu_count   <= '0;
            other_count <= '0;
        end else if (instruction == '0) begin
            nop_count <= nop_count + 1'b1;      // all-zero word
        end else if (is_jmp) begin
            jmp_count <= jmp_count + 1'b1;
        end else if (opcode == isa_pkg::OP_ALU) begin
            alu_count <= alu_count + 1'b1;
        end else begin
            other_count <= other_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  isa_pkg::instr_t     instruction,
    input  isa_pkg::word_t      pc,
    input  isa_pkg::word_t      fwd_r1,
    input  isa_pkg::word_t      fwd_r2,
    input  isa_pkg::word_t      fwd_dst,
    output pipe_pkg::pipe_rec_t id_out
);

    isa_pkg::opcode_t    opcode;
    logic [1:0]          subop;
    logic [2:0]          alu_subop;
    logic [2:0]          incr_code;
    logic                reg_ofs;
    logic [14:0]         imm15;
    logic [15:0]         imm16;
    logic [25:0]         jmp_target;
    isa_pkg::word_t      offset;
    pipe_pkg::pipe_rec_t rec;

    //////////////////////////////////////////////////
    // field split

    assign opcode     = instruction[isa_pkg::OPC_HI:isa_pkg::OPC_LO];
    assign subop      = instruction[isa_pkg::SUBOP_HI:isa_pkg::SUBOP_LO];
    assign alu_subop  = instruction[isa_pkg::SUBOP_HI:isa_pkg::ALU_SUBOP_LO];
    assign incr_code  = instruction[isa_pkg::INCR_HI:isa_pkg::INCR_LO];
    assign reg_ofs    = instruction[isa_pkg::ROFS_BIT];
    assign imm15      = instruction[isa_pkg::IMM15_HI:isa_pkg::IMM15_LO];
    assign imm16      = instruction[isa_pkg::IMM16_HI:isa_pkg::IMM16_LO];
    assign jmp_target = instruction[isa_pkg::JTGT_HI:isa_pkg::JTGT_LO];

    // register offset or sign-extended immediate
    assign offset = reg_ofs ? fwd_r2 : {{17{imm15[14]}}, imm15};

    //////////////////////////////////////////////////
    // opcode decode

    always_comb begin
        rec         = '0;
        rec.dst_r   = instruction[isa_pkg::DST_HI:isa_pkg::DST_LO];
        rec.src_r1  = instruction[isa_pkg::SRC1_HI:isa_pkg::SRC1_LO];
        rec.src_r2  = instruction[isa_pkg::SRC2_HI:isa_pkg::SRC2_LO];
        rec.val_r1  = fwd_r1;
        rec.val_r2  = fwd_r2;
        rec.val_dst = fwd_dst;

        // increment amount, codes 0 and 4 mean none
        rec.incr_r2_enable = 1'b1;
        case (incr_code)
            3'd1: rec.incr_r2 = 4'sd1;
            3'd2: rec.incr_r2 = 4'sd2;
            3'd3: rec.incr_r2 = 4'sd4;
            3'd5: rec.incr_r2 = -4'sd1;
            3'd6: rec.incr_r2 = -4'sd2;
            3'd7: rec.incr_r2 = -4'sd4;
            default: begin
                rec.incr_r2        = '0;
                rec.incr_r2_enable = 1'b0;
            end
        endcase

        case (opcode)
            isa_pkg::OP_LDR: begin
                case (subop)
                    2'd0: begin                         // register move
                        rec.write_reg = (rec.dst_r != rec.src_r1);
                        rec.val_dst   = fwd_r1;
                    end
                    2'd1: begin                         // load high half
                        rec.val_dst[31:16] = imm16;
                        rec.write_reg      = 1'b1;
                        rec.incr_r2_enable = 1'b0;
                    end
                    2'd2: begin                         // load low half
                        rec.val_dst[15:0]  = imm16;
                        rec.write_reg      = 1'b1;
                        rec.incr_r2_enable = 1'b0;
                    end
                    default: begin                      // load from memory
                        rec.read_mem       = 1'b1;
                        rec.write_reg      = 1'b1;
                        rec.incr_r2_enable = reg_ofs;
                        rec.val_r2         = offset;
                    end
                endcase
            end
            isa_pkg::OP_STR: begin
                rec.write_mem      = 1'b1;
                rec.val_r2         = offset;
                rec.incr_r2_enable = reg_ofs;
            end
            isa_pkg::OP_JMPUNC: begin
                rec.jmpunc         = 1'b1;
                rec.incr_r2_enable = reg_ofs;
                case (subop)
                    2'd0: begin                         // absolute
                        rec.val_r1         = {6'd0, jmp_target};
                        rec.val_r2         = '0;
                        rec.incr_r2_enable = 1'b0;
                    end
                    2'd1: begin                         // relative
                        rec.val_r1 = pc;
                        rec.val_r2 = offset;
                    end
                    2'd2: begin                         // call
                        rec.val_r1    = pc;
                        rec.val_r2    = offset;
                        rec.val_dst   = pc;             // return address
                        rec.write_reg = 1'b1;
                    end
                    default: begin                      // return through dst
                        rec.val_r1 = fwd_dst;
                        rec.val_r2 = '0;
                    end
                endcase
            end
            isa_pkg::OP_JMPF: begin
                // conditional jumps, all pc relative
                rec.val_r1         = pc;
                rec.val_r2         = offset;
                rec.incr_r2_enable = reg_ofs;
                case (subop)
                    2'd0:    rec.jmpz  = 1'b1;
                    2'd1:    rec.jmpnz = 1'b1;
                    2'd2:    rec.jmpc  = 1'b1;
                    default: rec.jmpnc = 1'b1;
                endcase
            end
            isa_pkg::OP_ALU: begin
                rec.write_reg = (alu_subop != 3'd7);    // cmp only sets flags
                case (alu_subop)
                    3'd0:    rec.and_op = 1'b1;
                    3'd1:    rec.or_op  = 1'b1;
                    3'd2:    rec.xor_op = 1'b1;
                    3'd3:    rec.add_op = 1'b1;
                    3'd4:    rec.mul_op = 1'b1;
                    3'd5:    rec.shl_op = 1'b1;
                    3'd6:    rec.shr_op = 1'b1;
                    default: rec.cmp_op = 1'b1;
                endcase
            end
            isa_pkg::OP_LDRF: begin
                // load of a flag, the jump bit names which one
                rec.ldrf_op   = 1'b1;
                rec.write_reg = 1'b1;
                case (subop)
                    2'd0:    rec.jmpz  = 1'b1;
                    2'd1:    rec.jmpnz = 1'b1;
                    2'd2:    rec.jmpc  = 1'b1;
                    default: rec.jmpnc = 1'b1;
                endcase
            end
            default: rec = '0;                          // unknown opcode
        endcase
    end

    //////////////////////////////////////////////////
    // pipeline register, held while stalled

    always_ff @(posedge clk) begin
        if (reset) begin
            id_out <= '0;
        end else if (!stall) begin
            id_out <= rec;
        end
    end

endmodule

`default_nettype wire

// File: design/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  isa_pkg::reg_idx_t idx,
    input  isa_pkg::word_t    rf_val,
    input  pipe_pkg::wb_rec_t wb_ex,
    input  pipe_pkg::wb_rec_t wb_mem,
    output isa_pkg::word_t    val
);

    logic mem_dst_hit;
    logic ex_dst_hit;
    logic ex_r2_hit;

    // index matches against each live write-back
    assign mem_dst_hit = wb_mem.write_reg && (wb_mem.dst_r == idx);
    assign ex_dst_hit  = wb_ex.write_reg && (wb_ex.dst_r == idx);
    assign ex_r2_hit   = wb_ex.incr_r2_enable && (wb_ex.src_r2 == idx);

    //////////////////////////////////////////////////
    // value select

    // memory load first, it is the newest value
    // in flight for a given register
    always_comb begin
        if (mem_dst_hit) begin
            val = wb_mem.val_dst;
        end else if (ex_dst_hit) begin
            val = wb_ex.val_dst;            // ex stage result
        end else if (ex_r2_hit) begin
            val = wb_ex.val_r2;             // auto-incremented r2
        end else begin
            val = rf_val;
        end
    end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file #(
    parameter int NUM_REGS = isa_pkg::NUM_REGS
) (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::reg_idx_t rd_idx0,
    input  isa_pkg::reg_idx_t rd_idx1,
    input  isa_pkg::reg_idx_t rd_idx2,
    input  pipe_pkg::wb_rec_t wb_ex,
    input  pipe_pkg::wb_rec_t wb_mem,
    output isa_pkg::word_t    rd_val0,
    output isa_pkg::word_t    rd_val1,
    output isa_pkg::word_t    rd_val2
);

    isa_pkg::word_t regs [NUM_REGS];

    //////////////////////////////////////////////////
    // write ports

    // written in rising priority order so the last
    // active port wins on a shared index
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_ex.write_reg) begin
                regs[wb_ex.dst_r] <= wb_ex.val_dst;     // ex result
            end
            if (wb_ex.incr_r2_enable) begin
                regs[wb_ex.src_r2] <= wb_ex.val_r2;     // incremented r2
            end
            if (wb_mem.write_reg) begin
                regs[wb_mem.dst_r] <= wb_mem.val_dst;   // memory load
            end
        end
    end

    //////////////////////////////////////////////////
    // asynchronous reads

    assign rd_val0 = regs[rd_idx0];
    assign rd_val1 = regs[rd_idx1];
    assign rd_val2 = regs[rd_idx2];

endmodule

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    //////////////////////////////////////////////////
    // decoded record handed to the execute stage

    typedef struct packed {
        isa_pkg::reg_idx_t dst_r;
        isa_pkg::reg_idx_t src_r1;
        isa_pkg::reg_idx_t src_r2;
        isa_pkg::word_t    val_r1;
        isa_pkg::word_t    val_r2;     // offset for memory and jumps
        isa_pkg::word_t    val_dst;
        isa_pkg::incr_t    incr_r2;
        logic              incr_r2_enable;
        logic              read_mem;
        logic              write_mem;
        logic              write_reg;
        // alu operations
        logic              mul_op;
        logic              add_op;
        logic              or_op;
        logic              and_op;
        logic              xor_op;
        logic              shl_op;
        logic              shr_op;
        logic              cmp_op;
        logic              ldrf_op;
        // jumps, the flag kinds also qualify ldrf
        logic              jmpunc;
        logic              jmpz;
        logic              jmpnz;
        logic              jmpc;
        logic              jmpnc;
    } pipe_rec_t;

    //////////////////////////////////////////////////
    // write-back subset coming back from later stages

    typedef struct packed {
        logic              write_reg;
        isa_pkg::reg_idx_t dst_r;
        isa_pkg::word_t    val_dst;
        logic              incr_r2_enable;  // src_r2 write after increment
        isa_pkg::reg_idx_t src_r2;
        isa_pkg::word_t    val_r2;
    } wb_rec_t;

endpackage

`default_nettype wire

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    //////////////////////////////////////////////////
    // word types

    typedef logic [31:0] word_t;           // data or address
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  opcode_t;         // major opcode, bits 31..28
    typedef logic signed [3:0] incr_t;     // src_r2 auto-increment

    localparam int NUM_REGS = 32;

    //////////////////////////////////////////////////
    // major opcodes, anything else is unknown

    localparam opcode_t OP_LDR    = 4'd0;
    localparam opcode_t OP_STR    = 4'd1;
    localparam opcode_t OP_JMPUNC = 4'd2;
    localparam opcode_t OP_JMPF   = 4'd3;
    localparam opcode_t OP_ALU    = 4'd4;
    localparam opcode_t OP_LDRF   = 4'd5;

    //////////////////////////////////////////////////
    // instruction field positions

    localparam int OPC_HI       = 31;
    localparam int OPC_LO       = 28;
    localparam int DST_HI       = 4;
    localparam int DST_LO       = 0;
    localparam int SRC1_HI      = 9;
    localparam int SRC1_LO      = 5;
    localparam int SRC2_HI      = 14;
    localparam int SRC2_LO      = 10;
    localparam int SUBOP_HI     = 27;
    localparam int SUBOP_LO     = 26;
    localparam int ALU_SUBOP_LO = 25;  // alu subop is one bit wider
    localparam int ROFS_BIT     = 25;  // offset from src_r2 instead of imm
    localparam int INCR_HI      = 24;
    localparam int INCR_LO      = 22;
    localparam int IMM15_HI     = 24;
    localparam int IMM15_LO     = 10;
    localparam int IMM16_HI     = 20;
    localparam int IMM16_LO     = 5;
    localparam int JTGT_HI      = 25;  // absolute jump target
    localparam int JTGT_LO      = 0;

endpackage

`default_nettype wire
